//--- run_sim.sh
#!/bin/sh
# builds tb_uart with Verilator and runs it; sim.log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f uart.f \
    --top-module tb_uart -o tb_uart > build.log 2>&1 \
    && ./obj_dir/tb_uart > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "FAIL: build or run did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- serial_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no rx buffer: o_rx is valid only in the o_rx_valid cycle
// a new frame needs a falling edge, so a stuck-low line is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module serial_rx (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_rx,          // async serial line
    output logic                 o_rx_valid,    // one-cycle strobe
    output uart_pkg::rx_byte_t   o_rx           // byte and framing flag
);
    import uart_pkg::*;

    localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
    localparam baud_cnt_t HALF_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);

    rx_state_e  state;
    baud_cnt_t  baud_cnt;                       // clocks to next sample
    logic [2:0] bit_idx;
    byte_t      data_sr;                        // fills from the top, LSB first
    logic       rx_meta;                        // first sync stage
    logic       rx_sync;                        // safe to use
    logic       rx_prev;                        // for edge detect
    logic       sample;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;                    // idle line level
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign sample = (baud_cnt == '0);           // mid-bit point

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;                 // strobe, one cycle
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state    <= RX_START;   // falling edge, maybe start
                        baud_cnt <= HALF_LAST;
                    end
                end
                RX_START: begin
                    baud_cnt <= sample ? BIT_LAST : baud_cnt - 1'b1;
                    if (sample) begin
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // high again is a glitch
                    end
                end
                RX_DATA: begin
                    baud_cnt <= sample ? BIT_LAST : baud_cnt - 1'b1;
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    baud_cnt <= baud_cnt - 1'b1;
                    if (sample) begin
                        o_rx_valid <= 1'b1;
                        state      <= RX_IDLE;  // rearm on next falling edge
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // payload path, no reset
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && sample) begin
            data_sr <= {rx_sync, data_sr[7:1]};
        end
        if (state == RX_STOP && sample) begin
            o_rx.data      <= data_sr;
            o_rx.frame_err <= !rx_sync;         // stop bit must read 1
        end
    end

endmodule

`default_nettype wire

//--- serial_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 only with one idle cycle between back-to-back frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module serial_tx (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_empty,       // fifo has nothing
    input  wire uart_pkg::byte_t i_head,        // show-ahead fifo head
    output logic                 o_pop,         // take head this cycle
    output logic                 o_busy,        // pop through end of stop bit
    output logic                 o_tx           // serial line that idles high
);
    import uart_pkg::*;

    localparam baud_cnt_t BIT_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);

    tx_state_e  state;
    baud_cnt_t  baud_cnt;                       // clocks left in this bit
    logic [2:0] bit_idx;                        // data bit on the line
    logic [8:0] shift_sr;                       // bit 0 drives the line
    logic       baud_stb;

    assign baud_stb = (baud_cnt == '0);         // last clock of a bit
    assign o_pop    = (state == TX_IDLE) && !i_empty;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            shift_sr <= '1;                     // line high
        end else if (o_pop) begin
            state    <= TX_START;
            baud_cnt <= BIT_LAST;
            bit_idx  <= '0;
            shift_sr <= {i_head, 1'b0};         // byte behind the start bit
        end else if (state != TX_IDLE) begin
            baud_cnt <= baud_stb ? BIT_LAST : baud_cnt - 1'b1;
            if (baud_stb) begin
                shift_sr <= {1'b1, shift_sr[8:1]};  // ones shift in to form the stop bit
                case (state)
                    TX_START: state <= TX_DATA;
                    TX_DATA: begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                    TX_STOP: state <= TX_IDLE;  // frame done
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

    assign o_tx   = shift_sr[0];
    assign o_busy = o_pop || (state != TX_IDLE);

    // the line rests high whenever no frame is in flight
    a_idle_line_high: assert property (@(posedge i_clk) disable iff (i_rst)
        !o_busy |-> o_tx);

endmodule

`default_nettype wire

//--- tb_uart.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run from the project root, reads uart_stimulus.txt there
// o_tx loops back to i_rx except while a frame is injected
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "uart_defines.svh"

`default_nettype none

module tb_uart;
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;        // clocks per serial bit

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic        i_req;
    byte_t       i_data;
    logic        o_ack;
    logic        o_tx;
    logic        o_tx_busy;
    logic        o_rx_valid;
    rx_byte_t    o_rx;
    logic        rx_line;                           // what the receiver sees
    logic        inject_en;                         // bit-banged frame owns the line
    logic        inject_line;

    rx_byte_t    exp_q[$];                          // every byte sent, in order
    rx_byte_t    got_q[$];                          // every byte received
    string       cmd_op[$];
    int          cmd_val[$];
    int          cmd_stop[$];
    int          cmd_err[$];
    int          error_count = 0;
    int          checked = 0;                       // pairs compared so far
    int          extra_seen = 0;                    // surplus bytes already reported
    longint      watchdog_ns = 0;
    logic [31:0] rand_state = 32'd83;               // lcg seed

    uart_top uut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (i_req),
        .i_data     (i_data),
        .o_ack      (o_ack),
        .o_tx       (o_tx),
        .o_tx_busy  (o_tx_busy),
        .i_rx       (rx_line),
        .o_rx_valid (o_rx_valid),
        .o_rx       (o_rx)
    );

    assign rx_line = inject_en ? inject_line : o_tx;   // loopback mux

    always #5 i_clk = ~i_clk;                       // 10 ns period

    // receive monitor, records only
    always @(negedge i_clk) begin
        if (!i_rst && o_rx_valid) begin
            got_q.push_back(o_rx);
        end
    end

    // armed once the stimulus length is known
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    // one four-phase handshake, latency in rising edges from req to ack
    task automatic send_byte(input byte_t b, input logic exp_err, output int latency);
        int n;
        exp_q.push_back(rx_byte_t'({b, exp_err}));
        @(posedge i_clk);
        i_data <= b;
        i_req  <= 1'b1;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_ack);
        latency = n - 1;
        @(posedge i_clk);
        i_req <= 1'b0;
        do begin
            @(negedge i_clk);
        end while (o_ack);                          // data free to change after this
    endtask

    task automatic inject_frame(input byte_t b, input logic stop_bit, input logic exp_err);
        logic [9:0] frame;
        frame = {stop_bit, b, 1'b0};                // start bit goes out first
        exp_q.push_back(rx_byte_t'({b, exp_err}));
        @(posedge i_clk);
        inject_en <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            inject_line <= frame[i];
            repeat (CPB) @(posedge i_clk);
        end
        inject_line <= 1'b1;
        repeat (2 * CPB) @(posedge i_clk);          // idle high before handing back
        inject_en <= 1'b0;
    endtask

    // waits for outstanding bytes and an idle transmitter, then compares in order
    task automatic drain_and_compare();
        int waited;
        int limit;
        waited = 0;
        limit  = (exp_q.size() - got_q.size() + 3) * 12 * CPB;
        while ((got_q.size() < exp_q.size() || o_tx_busy) && waited < limit) begin
            @(negedge i_clk);
            waited++;
        end
        if (got_q.size() < exp_q.size()) begin
            $display("%0d sent bytes never came back", exp_q.size() - got_q.size());
            error_count++;
        end
        while (checked < exp_q.size() && checked < got_q.size()) begin
            check_value("o_rx.data", 32'(got_q[checked].data), 32'(exp_q[checked].data));
            check_value("o_rx.frame_err", 32'(got_q[checked].frame_err),
                        32'(exp_q[checked].frame_err));
            checked++;
        end
        if (got_q.size() > exp_q.size() + extra_seen) begin
            $display("received %0d more bytes than were sent", got_q.size() - exp_q.size());
            extra_seen = got_q.size() - exp_q.size();
            error_count++;
        end
    endtask

    initial begin
        int     fd;
        int     n;
        string  line;
        string  op;
        int     v;
        int     s;
        int     e;
        int     lat;
        int     max_lat;
        int     errs_before;
        longint total_bytes;
        longint idle_bits;
        byte_t  b;

        i_rst       = 1'b1;
        i_req       = 1'b0;
        i_data      = '0;
        inject_en   = 1'b0;
        inject_line = 1'b1;
        total_bytes = 0;
        idle_bits   = 0;

        fd = $fopen("uart_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open uart_stimulus.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %h %h %h", op, v, s, e) == 4) begin
                    cmd_op.push_back(op);
                    cmd_val.push_back(v);
                    cmd_stop.push_back(s);
                    cmd_err.push_back(e);
                    if (op == "BURST" || op == "RAND") begin
                        total_bytes += v;
                    end else if (op == "IDLE") begin
                        idle_bits += v;
                    end else begin
                        total_bytes += 1;
                    end
                end
            end
            $fclose(fd);
        end
        watchdog_ns = ((total_bytes + 20) * 12 + idle_bits) * CPB * 10;

        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_value("o_tx", 32'(o_tx), 32'd1);      // line idles high
        check_value("o_ack", 32'(o_ack), 32'd0);
        check_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
        check_value("o_tx_busy", 32'(o_tx_busy), 32'd0);
        $display("test 0 RESET: %0d errors", error_count);

        for (int i = 0; i < cmd_op.size(); i++) begin
            errs_before = error_count;
            if (cmd_op[i] == "SEND") begin
                send_byte(byte_t'(cmd_val[i]), 1'(cmd_err[i]), lat);
                check_value("o_ack latency", 32'(lat), 32'd2);   // fifo has room here
                drain_and_compare();
            end else if (cmd_op[i] == "BURST" || cmd_op[i] == "RAND") begin
                max_lat = 0;
                for (int k = 0; k < cmd_val[i]; k++) begin
                    if (cmd_op[i] == "RAND") begin
                        rand_state = lcg_next(rand_state);
                        b = rand_state[23:16];      // upper bits, better spread
                    end else begin
                        b = byte_t'(8'hA0 + k);
                    end
                    send_byte(b, 1'(cmd_err[i]), lat);
                    if (lat > max_lat) begin
                        max_lat = lat;
                    end
                end
                // one byte leaves at once, so depth + 2 handshakes must stall
                if (cmd_val[i] > `UART_FIFO_DEPTH + 2) begin
                    check_value("o_ack held off", 32'(max_lat > 2), 32'd1);
                end
                drain_and_compare();
            end else if (cmd_op[i] == "INJECT") begin
                inject_frame(byte_t'(cmd_val[i]), 1'(cmd_stop[i]), 1'(cmd_err[i]));
                drain_and_compare();
            end else if (cmd_op[i] == "IDLE") begin
                repeat (cmd_val[i] * CPB) @(posedge i_clk);   // catches stray bytes
                drain_and_compare();
            end else begin
                $display("unknown command %s in the stimulus file", cmd_op[i]);
                error_count++;
            end
            $display("test %0d %s 0x%02h: %0d errors", i + 1, cmd_op[i], cmd_val[i],
                     error_count - errs_before);
        end

        $display("%0d tests, %0d bytes sent, %0d received, %0d errors",
                 cmd_op.size() + 1, exp_q.size(), got_q.size(), error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart.f
+incdir+.
uart_pkg.sv
uart_host_port.sv
uart_byte_fifo.sv
serial_tx.sv
serial_rx.sv
uart_top.sv
tb_uart.sv

//--- uart_byte_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// show-ahead head, DEPTH no larger than UART_FIFO_DEPTH
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_byte_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_push,        // write strobe
    input  wire uart_pkg::byte_t i_push_data,
    input  wire                  i_pop,         // head consumed this cycle
    output uart_pkg::byte_t      o_head,        // valid whenever !o_empty
    output logic                 o_empty,
    output logic                 o_full
);
    import uart_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;    // pointer width
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

    byte_t         mem [DEPTH];                 // storage, not reset
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    fifo_cnt_t     count;                       // occupancy
    logic          do_push;
    logic          do_pop;

    assign do_push = i_push && !o_full;         // guarded, see asserts
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;   // wrap for any depth
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    assign o_head  = mem[rd_ptr];               // show-ahead read
    assign o_empty = (count == '0);
    assign o_full  = (count == fifo_cnt_t'(DEPTH));

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pop |-> !o_empty);

    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
        i_push |-> !o_full);

endmodule

`default_nettype wire

//--- uart_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sim timing only: CLK_FREQ must be an exact multiple of BAUD_RATE
// FIFO count width follows UART_FIFO_DEPTH, so no FIFO may be deeper
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

`default_nettype none

// system clock in Hz
`define UART_CLK_FREQ      8_000_000

// serial line rate, bits per second
`define UART_BAUD_RATE     1_000_000

// clocks per serial bit, 8 for the values above
`define UART_CLKS_PER_BIT  (`UART_CLK_FREQ / `UART_BAUD_RATE)

// transmit buffer entries
`define UART_FIFO_DEPTH    8

`default_nettype wire

`endif

//--- uart_host_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host must hold i_data steady until o_ack drops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module uart_host_port (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_req,          // host request level
    input  wire uart_pkg::byte_t i_data,        // stable while i_req high
    output logic                o_ack,          // high from push until req drops
    input  wire                 i_full,         // fifo back-pressure
    output logic                o_push,         // one-cycle write strobe
    output uart_pkg::byte_t     o_push_data
);
    import uart_pkg::*;

    hs_state_e state;
    byte_t     data_q;                          // byte captured on req

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= HS_WAIT_REQ;
        end else begin
            case (state)
                HS_WAIT_REQ: begin
                    if (i_req) begin
                        state <= HS_PUSH;       // push follows next cycle
                    end
                end
                HS_PUSH: begin
                    if (!i_full) begin
                        state <= HS_WAIT_DROP;  // push lands this cycle
                    end
                end
                HS_WAIT_DROP: begin
                    if (!i_req) begin
                        state <= HS_WAIT_REQ;   // ack falls next cycle
                    end
                end
                default: state <= HS_WAIT_REQ;
            endcase
        end
    end

    // takes i_data as the request is first seen
    always_ff @(posedge i_clk) begin
        if (state == HS_WAIT_REQ && i_req) begin
            data_q <= i_data;
        end
    end

    assign o_push      = (state == HS_PUSH) && !i_full;    // held off while full
    assign o_push_data = data_q;
    assign o_ack       = (state == HS_WAIT_DROP);

    // ack only answers a live request
    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_ack) |-> $past(i_req));

endmodule

`default_nettype wire

//--- uart_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths follow uart_defines.svh, so retune there only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

    typedef logic [7:0] byte_t;                                         // serial payload
    typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt_t;          // counts down a bit time
    typedef logic [$clog2(`UART_FIFO_DEPTH+1)-1:0] fifo_cnt_t;          // 0..depth inclusive

    // received byte plus its stop-bit verdict
    typedef struct packed {
        byte_t data;                                                    // LSB first on the line
        logic  frame_err;                                               // stop sample was 0
    } rx_byte_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        HS_WAIT_REQ, HS_PUSH, HS_WAIT_DROP
    } hs_state_e;

endpackage

`default_nettype wire

//--- uart_stimulus.txt
# op  value stop exp_err   (value, stop and exp_err in hex)
# SEND byte, BURST/RAND count, INJECT byte with stop bit, IDLE bit times
SEND    5a  1  0
IDLE    14  1  0
SEND    a5  1  0
BURST   0c  1  0
IDLE    14  1  0
RAND    10  1  0
IDLE    14  1  0
INJECT  3c  0  1
SEND    c3  1  0
IDLE    14  1  0
INJECT  81  1  0
SEND    00  1  0
SEND    ff  1  0
IDLE    14  1  0

//--- uart_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tx and rx are independent, loop o_tx to i_rx outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_top (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_req,         // host handshake
    input  wire uart_pkg::byte_t i_data,
    output logic                 o_ack,
    output logic                 o_tx,          // serial out
    output logic                 o_tx_busy,
    input  wire                  i_rx,          // serial in
    output logic                 o_rx_valid,
    output uart_pkg::rx_byte_t   o_rx
);
    import uart_pkg::*;

    logic  fifo_push;                           // host port to fifo
    byte_t fifo_push_data;
    logic  fifo_full;
    logic  fifo_pop;                            // fifo to transmitter
    byte_t fifo_head;
    logic  fifo_empty;

    uart_host_port u_host_port (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .i_data      (i_data),
        .o_ack       (o_ack),
        .i_full      (fifo_full),
        .o_push      (fifo_push),
        .o_push_data (fifo_push_data)
    );

    uart_byte_fifo #(
        .DEPTH (`UART_FIFO_DEPTH)
    ) u_fifo (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_push      (fifo_push),
        .i_push_data (fifo_push_data),
        .i_pop       (fifo_pop),
        .o_head      (fifo_head),
        .o_empty     (fifo_empty),
        .o_full      (fifo_full)
    );

    serial_tx u_tx (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_empty (fifo_empty),
        .i_head  (fifo_head),
        .o_pop   (fifo_pop),
        .o_busy  (o_tx_busy),
        .o_tx    (o_tx)
    );

    serial_rx u_rx (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rx       (i_rx),
        .o_rx_valid (o_rx_valid),
        .o_rx       (o_rx)
    );

endmodule

`default_nettype wire
